// ==== code_rom.hex ====
// one instruction word per line, from address 0 upward
// fields: opcode[15:12] rd[11:8] then rs[7:4] or imm, target or port in [7:0]
0401    // 00 op_ldi  r4, 0x01  mask for mailbox full
0502    // 01 op_ldi  r5, 0x02  mask for tx busy
b001    // 02 op_in   r0, status
3040    // 03 op_and  r0, r4
9002    // 04 op_jz   r0, 02  mailbox empty, poll again
b100    // 05 op_in   r1, mailbox  read clears full
02ff    // 06 op_ldi  r2, 0xff
5210    // 07 op_xor  r2, r1
c202    // 08 op_out  r2, led
7310    // 09 op_mov  r3, r1
6330    // 0a op_swap r3, r3
1310    // 0b op_add  r3, r1  low byte is hi + lo
b001    // 0c op_in   r0, status
3050    // 0d op_and  r0, r5
a00c    // 0e op_jnz  r0, 0c  transmitter still busy
c303    // 0f op_out  r3, uart
8000    // 10 op_jmp  00
8000    // 11 only prefetched behind the jump, squashed
8000    // 12 only prefetched, arrives invalid

// ==== code_rom.sv ====
`timescale 1ns/1ps

module code_rom (
    input  logic            clk50m,
    input  mcu_pkg::pc_t    addr,
    output mcu_pkg::word_t  instr
);

    // program image, one instruction word per line of the hex file
    mcu_pkg::word_t mem [mcu_pkg::rom_depth];

    // loaded once at elaboration
    initial begin
        $readmemh("code_rom.hex", mem);
    end

    // registered read, word appears one clock after addr
    always_ff @(posedge clk50m) begin
        instr <= mem[addr];
    end

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
    input  logic                 clk50m,
    input  logic                 rst,
    input  mcu_pkg::fetch_word_t fetch_word,
    output logic                 redirect,
    output mcu_pkg::pc_t         redirect_pc,
    output mcu_pkg::io_req_t     io_req,
    input  mcu_pkg::word_t       io_rdata
);

    mcu_pkg::opcode_t  opcode;
    mcu_pkg::reg_idx_t rd_idx;
    mcu_pkg::reg_idx_t rs_idx;
    mcu_pkg::byte_t    imm;
    mcu_pkg::word_t    rd_val;
    mcu_pkg::word_t    rs_val;
    mcu_pkg::word_t    result;
    logic              reg_wr;
    logic              take_jump;
    logic              live;

    // register file, no reset
    mcu_pkg::word_t regfile [mcu_pkg::reg_count];

    // field split
    assign opcode = mcu_pkg::opcode_t'(fetch_word.instr[15:12]);
    assign rd_idx = fetch_word.instr[11:8];
    assign rs_idx = fetch_word.instr[7:4];
    assign imm    = fetch_word.instr[7:0];

    // word after a taken jump is squashed while redirect is high
    assign live = fetch_word.valid && !redirect;

    // async read, write lands at end of cycle so no forwarding needed
    assign rd_val = regfile[rd_idx];
    assign rs_val = regfile[rs_idx];

    always_comb begin
        result    = '0;
        reg_wr    = 1'b0;
        take_jump = 1'b0;
        io_req    = '0;
        // port number sits in the low nibble of the immediate
        io_req.port  = imm[3:0];
        io_req.wdata = rd_val;
        case (opcode)
            mcu_pkg::op_ldi: begin
                result = {8'h00, imm};
                reg_wr = 1'b1;
            end
            mcu_pkg::op_add: begin
                result = rd_val + rs_val;
                reg_wr = 1'b1;
            end
            mcu_pkg::op_sub: begin
                result = rd_val - rs_val;
                reg_wr = 1'b1;
            end
            mcu_pkg::op_and: begin
                result = rd_val & rs_val;
                reg_wr = 1'b1;
            end
            mcu_pkg::op_or: begin
                result = rd_val | rs_val;
                reg_wr = 1'b1;
            end
            mcu_pkg::op_xor: begin
                result = rd_val ^ rs_val;
                reg_wr = 1'b1;
            end
            mcu_pkg::op_swap: begin
                // byte swap of rs into rd
                result = {rs_val[7:0], rs_val[15:8]};
                reg_wr = 1'b1;
            end
            mcu_pkg::op_mov: begin
                result = rs_val;
                reg_wr = 1'b1;
            end
            mcu_pkg::op_jmp: take_jump = 1'b1;
            mcu_pkg::op_jz:  take_jump = (rd_val == '0);
            mcu_pkg::op_jnz: take_jump = (rd_val != '0);
            mcu_pkg::op_in: begin
                // port answers in the same cycle
                result           = io_rdata;
                reg_wr           = 1'b1;
                io_req.rd_strobe = live;
            end
            mcu_pkg::op_out: io_req.wr_strobe = live;
            default: ;
        endcase
    end

    always_ff @(posedge clk50m) begin
        if (live && reg_wr) begin
            regfile[rd_idx] <= result;
        end
    end

    // registered redirect, fetch drops one more word in flight
    always_ff @(posedge clk50m) begin
        if (rst) begin
            redirect <= 1'b0;
        end else begin
            redirect <= live && take_jump;
        end
    end

    always_ff @(posedge clk50m) begin
        redirect_pc <= imm;
    end

    // two bubbles, then the jump target itself shows up from fetch
    a_redirect_lands: assert property (
        @(posedge clk50m) disable iff (rst)
        redirect |-> ##2 (fetch_word.valid && fetch_word.pc == $past(redirect_pc, 2))
    );

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                 clk50m,
    input  logic                 rst,
    input  logic                 redirect,
    input  mcu_pkg::pc_t         redirect_pc,
    output mcu_pkg::pc_t         rom_addr,
    input  mcu_pkg::word_t       rom_instr,
    output mcu_pkg::fetch_word_t fetch_word
);

    // address going to the rom this cycle
    mcu_pkg::pc_t pc;
    // tag for the word the rom returns next cycle
    mcu_pkg::pc_t pc_q;
    logic         valid_q;

    assign rom_addr = pc;

    always_ff @(posedge clk50m) begin
        if (rst) begin
            pc      <= '0;
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            pc_q <= pc;
            if (redirect) begin
                // restart at target, word now in the rom is stale
                pc      <= redirect_pc;
                valid_q <= 1'b0;
            end else begin
                // wrap at end of rom
                if (pc == mcu_pkg::pc_t'(mcu_pkg::rom_depth - 1)) begin
                    pc <= '0;
                end else begin
                    pc <= pc + 1'b1;
                end
                valid_q <= 1'b1;
            end
        end
    end

    // rom output register doubles as the instruction register
    always_comb begin
        fetch_word.valid = valid_q;
        fetch_word.pc    = pc_q;
        fetch_word.instr = rom_instr;
    end

    // redirect comes from a jump two words back, its successor
    // must still be a live word when the redirect lands
    a_redirect_on_valid: assert property (
        @(posedge clk50m) disable iff (rst)
        redirect |-> fetch_word.valid
    );

endmodule

// ==== io_port.sv ====
`timescale 1ns/1ps

module io_port (
    input  logic             clk50m,
    input  logic             rst,
    input  mcu_pkg::io_req_t io_req,
    output mcu_pkg::word_t   io_rdata,
    input  mcu_pkg::word_t   host_data,
    input  logic             host_strobe,
    input  logic             tx_busy,
    output logic             tx_strobe,
    output mcu_pkg::byte_t   tx_byte,
    output mcu_pkg::byte_t   led
);

    mcu_pkg::word_t mbox;
    logic           full;
    mcu_pkg::word_t status;

    // polled by software, no other flow control
    always_comb begin
        status = '0;
        status[mcu_pkg::status_full_bit] = full;
        status[mcu_pkg::status_busy_bit] = tx_busy;
    end

    // read mux, answers in the same cycle as rd_strobe
    always_comb begin
        case (io_req.port)
            mcu_pkg::port_mailbox: io_rdata = mbox;
            mcu_pkg::port_status:  io_rdata = status;
            mcu_pkg::port_led:     io_rdata = {8'h00, led};
            default:               io_rdata = '0;
        endcase
    end

    // host word overwrites whatever sits in the box
    always_ff @(posedge clk50m) begin
        if (host_strobe) begin
            mbox <= host_data;
        end
    end

    always_ff @(posedge clk50m) begin
        if (rst) begin
            full <= 1'b0;
            led  <= '0;
        end else begin
            // new host word wins over a same-cycle read
            if (host_strobe) begin
                full <= 1'b1;
            end else if (io_req.rd_strobe && io_req.port == mcu_pkg::port_mailbox) begin
                full <= 1'b0;
            end
            if (io_req.wr_strobe && io_req.port == mcu_pkg::port_led) begin
                led <= io_req.wdata[7:0];
            end
        end
    end

    // uart write passed straight through as a strobe
    assign tx_strobe = io_req.wr_strobe && (io_req.port == mcu_pkg::port_uart);
    assign tx_byte   = io_req.wdata[7:0];

endmodule

// ==== mcu_pkg.sv ====
package mcu_pkg;

    // data path and address widths
    typedef logic [15:0] word_t;
    typedef logic [7:0]  pc_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  port_t;
    typedef logic [7:0]  byte_t;

    // program memory size, one word per pc value
    localparam int rom_depth = 256;

    // general purpose registers r0..r15
    localparam int reg_count = 16;

    // 115200 bps from 50 MHz
    localparam int baud_divisor = 434;
    localparam int baud_cnt_width = $clog2(baud_divisor);

    // i/o port map
    localparam port_t port_mailbox = 4'd0;
    localparam port_t port_status  = 4'd1;
    localparam port_t port_led     = 4'd2;
    localparam port_t port_uart    = 4'd3;

    // status word bit positions
    localparam int status_full_bit = 0;
    localparam int status_busy_bit = 1;

    // instr[15:12] opcode, [11:8] rd, [7:4] rs or [7:0] imm / target / port
    typedef enum logic [3:0] {
        op_ldi  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_swap = 4'h6,
        op_mov  = 4'h7,
        op_jmp  = 4'h8,
        op_jz   = 4'h9,
        op_jnz  = 4'ha,
        op_in   = 4'hb,
        op_out  = 4'hc
    } opcode_t;

    // fetch to execute
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } fetch_word_t;

    // execute to i/o port, strobes last one cycle
    typedef struct packed {
        logic  wr_strobe;
        logic  rd_strobe;
        port_t port;
        word_t wdata;
    } io_req_t;

endpackage

// ==== mcu_top.sv ====
`timescale 1ns/1ps

module mcu_top (
    input  logic           clk50m,
    input  logic           rst,
    input  mcu_pkg::word_t host_data,
    input  logic           host_strobe,
    output mcu_pkg::byte_t led,
    output logic           uart_txd
);

    // fetch side
    mcu_pkg::pc_t         rom_addr;
    mcu_pkg::word_t       rom_instr;
    mcu_pkg::fetch_word_t fetch_word;
    logic                 redirect;
    mcu_pkg::pc_t         redirect_pc;

    // i/o side
    mcu_pkg::io_req_t     io_req;
    mcu_pkg::word_t       io_rdata;
    logic                 tx_strobe;
    mcu_pkg::byte_t       tx_byte;
    logic                 tx_busy;

    code_rom rom0 (
        .clk50m (clk50m),
        .addr   (rom_addr),
        .instr  (rom_instr)
    );

    fetch_stage fetch0 (
        .clk50m      (clk50m),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rom_addr    (rom_addr),
        .rom_instr   (rom_instr),
        .fetch_word  (fetch_word)
    );

    exec_stage exec0 (
        .clk50m      (clk50m),
        .rst         (rst),
        .fetch_word  (fetch_word),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .io_req      (io_req),
        .io_rdata    (io_rdata)
    );

    io_port io0 (
        .clk50m      (clk50m),
        .rst         (rst),
        .io_req      (io_req),
        .io_rdata    (io_rdata),
        .host_data   (host_data),
        .host_strobe (host_strobe),
        .tx_busy     (tx_busy),
        .tx_strobe   (tx_strobe),
        .tx_byte     (tx_byte),
        .led         (led)
    );

    // transmitter runs straight off clk50m with its own divider
    uart_tx uart0 (
        .clk50m    (clk50m),
        .rst       (rst),
        .tx_strobe (tx_strobe),
        .tx_byte   (tx_byte),
        .txd       (uart_txd),
        .tx_busy   (tx_busy)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk50m,
    output logic rst
);

    // 20 ns period
    initial begin
        clk50m = 1'b0;
        forever #10 clk50m = ~clk50m;
    end

    // high for 8 rising edges, released on an edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk50m);
        rst <= 1'b0;
    end

endmodule

// ==== tb_mcu_top.sv ====
`timescale 1ns/1ps

module tb_mcu_top;

    localparam int half_bit = mcu_pkg::baud_divisor / 2;
    // a frame in flight plus the polling loop fits well inside this
    localparam int start_timeout = 15 * mcu_pkg::baud_divisor;

    logic           clk50m;
    logic           rst;
    mcu_pkg::word_t host_data;
    logic           host_strobe;
    mcu_pkg::byte_t led;
    logic           uart_txd;

    mcu_pkg::word_t d;
    mcu_pkg::word_t d_next;
    mcu_pkg::byte_t rx;

    // edge words, sums and led values worked out by hand
    mcu_pkg::word_t edge_word [4] = '{16'h0000, 16'hffff, 16'h00ff, 16'hff01};
    mcu_pkg::byte_t edge_sum  [4] = '{8'h00, 8'hfe, 8'hff, 8'h00};
    mcu_pkg::byte_t edge_led  [4] = '{8'hff, 8'h00, 8'h00, 8'hfe};

    tb_clock_gen clk_gen0 (
        .clk50m (clk50m),
        .rst    (rst)
    );

    mcu_top dut0 (
        .clk50m      (clk50m),
        .rst         (rst),
        .host_data   (host_data),
        .host_strobe (host_strobe),
        .led         (led),
        .uart_txd    (uart_txd)
    );

    // reference model of the polling program
    function automatic mcu_pkg::byte_t model_led(input mcu_pkg::word_t w);
        return w[7:0] ^ 8'hff;
    endfunction

    function automatic mcu_pkg::byte_t model_uart(input mcu_pkg::word_t w);
        return w[15:8] + w[7:0];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // outputs are read on the falling edge, away from the update edge
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk50m);
    endtask

    task automatic wait_reset_release();
        int i;
        i = 0;
        while (rst && i < 100) begin
            @(negedge clk50m);
            i++;
        end
        if (rst) begin
            fail_run("timeout: reset was never released");
        end
    endtask

    // one-cycle host strobe
    task automatic send_host_word(input mcu_pkg::word_t w);
        @(posedge clk50m);
        host_data   <= w;
        host_strobe <= 1'b1;
        @(posedge clk50m);
        host_strobe <= 1'b0;
    endtask

    task automatic wait_start_bit(input string name);
        int i;
        i = 0;
        @(negedge clk50m);
        while (uart_txd && i < start_timeout) begin
            @(negedge clk50m);
            i++;
        end
        if (uart_txd) begin
            fail_run($sformatf("timeout: no uart start bit seen in %s", name));
        end
    endtask

    // mid-bit sampling, lead = cycles already spent after the start edge
    task automatic sample_frame(input string name, input int lead,
                                output mcu_pkg::byte_t b);
        wait_cycles(half_bit - lead);
        check_value($sformatf("%s start bit", name), 16'd0, {15'd0, uart_txd});
        // lsb first
        for (int k = 0; k < 8; k++) begin
            wait_cycles(mcu_pkg::baud_divisor);
            b[k] = uart_txd;
        end
        wait_cycles(mcu_pkg::baud_divisor);
        check_value($sformatf("%s stop bit", name), 16'd1, {15'd0, uart_txd});
    endtask

    task automatic receive_byte(input string name, output mcu_pkg::byte_t b);
        wait_start_bit(name);
        sample_frame(name, 0, b);
    endtask

    task automatic expect_line_idle(input string name, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk50m);
            check_value($sformatf("%s idle line", name), 16'd1, {15'd0, uart_txd});
        end
    endtask

    task automatic run_word(input string name, input mcu_pkg::word_t w,
                            input mcu_pkg::byte_t exp_byte, input mcu_pkg::byte_t exp_led);
        mcu_pkg::byte_t b;
        send_host_word(w);
        receive_byte(name, b);
        check_value($sformatf("%s uart byte", name), {8'd0, exp_byte}, {8'd0, b});
        // rest of the stop bit, busy falls at its end
        wait_cycles(half_bit + 2);
        check_value($sformatf("%s led", name), {8'd0, exp_led}, {8'd0, led});
    endtask

    initial begin
        host_data   = '0;
        host_strobe = 1'b0;
        void'($urandom(32'h04dc_6fb9));
        wait_reset_release();

        // reset state, line must stay high
        expect_line_idle("reset state", 20);
        check_value("reset state led", 16'd0, {8'd0, led});

        d = mcu_pkg::word_t'($urandom);
        run_word("single word", d, model_uart(d), model_led(d));
        // exactly one byte per word
        expect_line_idle("single word", 3 * mcu_pkg::baud_divisor);

        for (int n = 0; n < 40; n++) begin
            d = mcu_pkg::word_t'($urandom);
            run_word($sformatf("random sequence %0d", n), d, model_uart(d), model_led(d));
        end

        // second word arrives while the first frame is on the line
        d      = mcu_pkg::word_t'($urandom);
        d_next = mcu_pkg::word_t'($urandom);
        send_host_word(d);
        wait_start_bit("overlap first");
        send_host_word(d_next);
        // two cycles of the start bit went to the host strobe
        sample_frame("overlap first", 2, rx);
        check_value("overlap first byte", {8'd0, model_uart(d)}, {8'd0, rx});
        receive_byte("overlap second", rx);
        check_value("overlap second byte", {8'd0, model_uart(d_next)}, {8'd0, rx});
        wait_cycles(half_bit + 2);
        check_value("overlap led", {8'd0, model_led(d_next)}, {8'd0, led});

        for (int e = 0; e < 4; e++) begin
            run_word($sformatf("edge value %h", edge_word[e]), edge_word[e],
                     edge_sum[e], edge_led[e]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic           clk50m,
    input  logic           rst,
    input  logic           tx_strobe,
    input  mcu_pkg::byte_t tx_byte,
    output logic           txd,
    output logic           tx_busy
);

    // stop, data lsb first, start; bit 0 is on the line
    logic [9:0]                          frame;
    logic [mcu_pkg::baud_cnt_width-1:0]  baud_cnt;
    logic [3:0]                          bit_cnt;
    logic                                baud_tick;

    assign baud_tick = (baud_cnt == mcu_pkg::baud_cnt_width'(mcu_pkg::baud_divisor - 1));

    // idle frame is all ones so the line rests high
    assign txd = frame[0];

    always_ff @(posedge clk50m) begin
        if (rst) begin
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (tx_strobe) begin
                // start bit goes out next cycle
                frame   <= {1'b1, tx_byte, 1'b0};
                tx_busy <= 1'b1;
            end
        end else if (baud_tick) begin
            baud_cnt <= '0;
            // shift ones in behind the stop bit
            frame    <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                // end of stop bit
                tx_busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // software must poll status before writing the uart port
    a_no_strobe_busy: assert property (
        @(posedge clk50m) disable iff (rst)
        tx_strobe |-> !tx_busy
    );

endmodule

// ==== vlog.f ====
mcu_pkg.sv
code_rom.sv
fetch_stage.sv
exec_stage.sv
io_port.sv
uart_tx.sv
mcu_top.sv
tb_clock_gen.sv
tb_mcu_top.sv
